/* logic/exec_cfg_pkg.sv */
/*
 * Field widths and the default data width of the execute stage.
 * Imported by the interfaces, the RTL units and the testbench.
 */
package exec_cfg_pkg;

    // Datapath ------------------------------
    localparam int XLEN_DEFAULT = 32; // Data width unless the top overrides it

    // Record fields -------------------------
    localparam int RD_W    = 5;  // Destination register address
    localparam int UOP_W   = 5;  // Micro-op code
    localparam int FU_W    = 5;  // One-hot functional unit select
    localparam int SIZE_W  = 2;  // Instruction size
    localparam int INSTR_W = 32; // Raw instruction word
    localparam int CAUSE_W = 6;  // Trap cause carried in operand B

endpackage

/* logic/exec_isa_pkg.sv */
/*
 * Functional-unit select bits and micro-op encodings of the execute stage.
 * The micro-op word is one union; each unit decodes its own view of it.
 */
package exec_isa_pkg;

    import exec_cfg_pkg::*;

    // Bit positions in the one-hot fu word
    localparam int P_FU_ALU = 0;
    localparam int P_FU_MUL = 1;
    localparam int P_FU_LSU = 2;
    localparam int P_FU_CFU = 3;
    localparam int P_FU_CSR = 4;

    // ALU view ------------------------------
    typedef enum logic [UOP_W-1:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        XOR  = 5'd2,
        OR   = 5'd3,
        AND  = 5'd4,
        SLL  = 5'd5,
        SRL  = 5'd6,
        SRA  = 5'd7,
        SLT  = 5'd8,
        SLTU = 5'd9
    } alu_op_e;

    // Control-flow view. Upper two bits give the class:
    // 00 conditional, 10 jump, 11 already resolved
    typedef enum logic [UOP_W-1:0] {
        BEQ       = 5'd0,
        BNE       = 5'd1,
        BLT       = 5'd2,
        BGE       = 5'd3,
        BLTU      = 5'd4,
        BGEU      = 5'd5,
        JMP       = 5'd16,
        JALI      = 5'd17,
        JALR      = 5'd18,
        TAKEN     = 5'd24,
        NOT_TAKEN = 5'd25
    } cfu_op_e;

    // Multiplier view
    typedef enum logic [UOP_W-1:0] {
        MUL   = 5'd0, // Low half of product
        MULHU = 5'd1  // High half, unsigned
    } mul_op_e;

    // Load/store view, load bit lowest
    typedef struct packed {
        logic [2:0] width; // Access width code
        logic       store;
        logic       load;
    } lsu_op_t;

    // One micro-op word, four readings of it
    typedef union packed {
        alu_op_e alu;
        cfu_op_e cfu;
        mul_op_e mul;
        lsu_op_t lsu;
    } exec_uop_u;

endpackage

/* logic/exec_op_if.sv */
/*
 * Stage-2 instruction record into the execute stage, with busy back upstream.
 * A record moves on an edge where valid is high and busy is low.
 */
interface exec_op_if import exec_cfg_pkg::*, exec_isa_pkg::*; #(
    parameter int XLEN = 32
) ();

    logic               valid;  // Record present
    logic               busy;   // Execute stage cannot take it
    logic [FU_W-1:0]    fu;     // One-hot unit select
    exec_uop_u          uop;    // Micro-op, decoded per unit
    logic [RD_W-1:0]    rd;     // Destination register
    logic [XLEN-1:0]    opr_a;
    logic [XLEN-1:0]    opr_b;
    logic [XLEN-1:0]    opr_c;
    logic               trap;   // Record raises a trap
    logic [SIZE_W-1:0]  size;   // Instruction size
    logic [INSTR_W-1:0] instr;  // Raw instruction word

    modport source (output valid, fu, uop, rd, opr_a, opr_b, opr_c, trap, size, instr,
                    input  busy);
    modport unit   (input  valid, fu, uop, rd, opr_a, opr_b, opr_c, trap, size, instr);
    modport stage  (input  valid, fu, uop, rd, opr_a, opr_b, opr_c, trap, size, instr,
                    output busy);

endinterface

/* logic/exec_alu_if.sv */
/*
 * ALU outputs shared by the branch unit and the stage-3 register.
 */
interface exec_alu_if #(
    parameter int XLEN = 32
) ();

    logic [XLEN-1:0] result;      // Selected ALU result
    logic [XLEN-1:0] sum;         // A + B, always computed
    logic            lt_signed;   // A < B, signed
    logic            lt_unsigned; // A < B, unsigned
    logic            eq;          // A == B

    modport alu  (output result, sum, lt_signed, lt_unsigned, eq);
    modport user (input  result, sum, lt_signed, lt_unsigned, eq);

endinterface

/* logic/exec_alu.sv */
/*
 * Combinational integer ALU. Also supplies the A+B sum for address
 * generation and jalr, and the compare flags used by branches.
 */
module exec_alu import exec_isa_pkg::*; #(
    parameter int XLEN = 32
) (
    exec_op_if.unit  op,  // Stage-2 record
    exec_alu_if.alu  res  // Results and flags
);

    localparam int SHW = $clog2(XLEN); // Shift amount width

    logic [XLEN-1:0] diff;  // A - B
    logic [SHW-1:0]  shamt; // Low bits of B

    // Always-on arithmetic ------------------
    assign res.sum         = op.opr_a + op.opr_b;
    assign diff            = op.opr_a - op.opr_b;
    assign shamt           = op.opr_b[SHW-1:0];

    assign res.eq          = op.opr_a == op.opr_b;
    assign res.lt_unsigned = op.opr_a < op.opr_b;
    assign res.lt_signed   = $signed(op.opr_a) < $signed(op.opr_b);

    // Result select -------------------------
    always_comb begin
        case (op.uop.alu)
            ADD:     res.result = res.sum;
            SUB:     res.result = diff;
            XOR:     res.result = op.opr_a ^ op.opr_b;
            OR:      res.result = op.opr_a | op.opr_b;
            AND:     res.result = op.opr_a & op.opr_b;
            SLL:     res.result = op.opr_a << shamt;
            SRL:     res.result = op.opr_a >> shamt;
            SRA:     res.result = $unsigned($signed(op.opr_a) >>> shamt); // Sign fill
            SLT:     res.result = {{(XLEN-1){1'b0}}, res.lt_signed};
            SLTU:    res.result = {{(XLEN-1){1'b0}}, res.lt_unsigned};
            default: res.result = '0; // Unused codes
        endcase
    end

endmodule

/* logic/exec_branch.sv */
/*
 * Branch resolution. Conditional branches become TAKEN or NOT_TAKEN from
 * the ALU flags; jumps keep their micro-op. Target has bit 0 cleared.
 */
module exec_branch import exec_isa_pkg::*; #(
    parameter int XLEN = 32
) (
    exec_op_if.unit   op,           // Stage-2 record
    exec_alu_if.user  alu,          // Compare flags and sum
    output exec_uop_u       o_cfu_uop,    // Rewritten micro-op
    output logic [XLEN-1:0] o_cfu_target  // Aligned target
);

    logic            cond;   // Conditional branch code
    logic            taken;  // Condition holds
    logic [XLEN-1:0] target; // Raw target before alignment

    // Condition evaluation ------------------
    always_comb begin
        cond  = 1'b1;
        taken = 1'b0;
        case (op.uop.cfu)
            BEQ:     taken = alu.eq;
            BNE:     taken = !alu.eq;
            BLT:     taken = alu.lt_signed;
            BGE:     taken = !alu.lt_signed;
            BLTU:    taken = alu.lt_unsigned;
            BGEU:    taken = !alu.lt_unsigned;
            default: cond  = 1'b0; // Jumps and resolved codes
        endcase
    end

    // Micro-op rewrite
    always_comb begin
        o_cfu_uop = op.uop; // Jumps pass through
        if (cond) begin
            o_cfu_uop.cfu = taken ? TAKEN : NOT_TAKEN;
        end
    end

    // jalr adds rs1 and offset, the rest arrive precomputed in C
    assign target       = (op.uop.cfu == JALR) ? alu.sum : op.opr_c;
    assign o_cfu_target = {target[XLEN-1:1], 1'b0};

endmodule

/* logic/exec_mul.sv */
/*
 * Iterative unsigned multiplier, one shift-add step per cycle.
 * Starts on a valid MUL record, is ready after XLEN cycles and holds
 * the double-width product until the record is accepted or flushed.
 */
module exec_mul import exec_isa_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              i_flush,       // Abort a running multiply
    exec_op_if.unit           op,            // Stage-2 record
    input  logic              i_accept,      // Record taken this cycle
    output logic              o_mul_ready,   // Product final
    output logic [2*XLEN-1:0] o_mul_product  // {high, low}
);

    localparam int CNT_W = $clog2(XLEN + 1); // Counts 0..XLEN

    logic              running_q; // Iterating
    logic              done_q;    // Product held
    logic [CNT_W-1:0]  cnt_q;     // Steps completed
    logic [2*XLEN-1:0] acc_q;     // {partial product, remaining multiplier}

    logic              start;     // New MUL record while idle
    logic              last;      // Final step this cycle
    logic [2*XLEN-1:0] step_in;
    logic [2*XLEN-1:0] step_out;
    logic [XLEN:0]     step_sum;  // High half plus addend, with carry

    assign start = op.valid && op.fu[P_FU_MUL] && !running_q && !done_q;
    assign last  = cnt_q == CNT_W'(XLEN - 1);

    // Shift-add step ------------------------
    // Multiplicand is read from B directly, the record is held while busy
    assign step_in  = running_q ? acc_q : {{XLEN{1'b0}}, op.opr_a};
    assign step_sum = {1'b0, step_in[2*XLEN-1:XLEN]}
                    + (step_in[0] ? {1'b0, op.opr_b} : {(XLEN+1){1'b0}});
    assign step_out = {step_sum, step_in[XLEN-1:1]}; // Shift right by one

    // Control -------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            running_q <= 1'b0;
            done_q    <= 1'b0;
            cnt_q     <= '0;
        end else if (i_flush) begin
            running_q <= 1'b0; // Abort
            done_q    <= 1'b0;
            cnt_q     <= '0;
        end else if (done_q && i_accept) begin
            done_q    <= 1'b0; // Back to idle
            cnt_q     <= '0;
        end else if (start || running_q) begin
            running_q <= !last;
            done_q    <= last;
            cnt_q     <= start ? CNT_W'(1) : cnt_q + 1'b1;
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (start || running_q) begin
            acc_q <= step_out;
        end
    end

    assign o_mul_ready   = done_q;
    assign o_mul_product = acc_q;

    // Counter stays in range across a whole multiply
    a_cnt_range: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cnt_q <= CNT_W'(XLEN));

endmodule

/* logic/exec_s3_register.sv */
/*
 * Stage-3 pipeline register of the execute stage. Selects operands A and B
 * by functional unit, inserts the trap cause, drives stage-2 busy and
 * holds its record while stage 3 is busy.
 */
module exec_s3_register import exec_cfg_pkg::*, exec_isa_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  logic               i_flush,         // Drop the held record
    exec_op_if.stage           op,              // Stage-2 record, busy out
    exec_alu_if.user           alu,             // ALU result and sum
    input  exec_uop_u          i_cfu_uop,       // Resolved branch micro-op
    input  logic [XLEN-1:0]    i_cfu_target,    // Aligned target
    input  logic               i_mul_ready,     // Product final
    input  logic [2*XLEN-1:0]  i_mul_product,   // {high, low}
    output logic               o_accept,        // Record taken this cycle
    input  logic               i_s3_busy,       // Stage 3 stalls
    output logic               o_s3_valid,
    output logic [RD_W-1:0]    o_s3_rd,
    output logic [UOP_W-1:0]   o_s3_uop,
    output logic [FU_W-1:0]    o_s3_fu,
    output logic [XLEN-1:0]    o_s3_opr_a,
    output logic [XLEN-1:0]    o_s3_opr_b,
    output logic               o_s3_trap,
    output logic [SIZE_W-1:0]  o_s3_size,
    output logic [INSTR_W-1:0] o_s3_instr
);

    logic              stall;     // Stage 2 cannot move
    logic              fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic [XLEN-1:0]   mul_lo, mul_hi;
    logic [CAUSE_W-1:0] cause;     // Trap cause from rd
    logic [XLEN-1:0]   n_opr_a, n_opr_b;
    logic [UOP_W-1:0]  n_uop;

    assign fu_alu = op.fu[P_FU_ALU];
    assign fu_mul = op.fu[P_FU_MUL];
    assign fu_lsu = op.fu[P_FU_LSU];
    assign fu_cfu = op.fu[P_FU_CFU];
    assign fu_csr = op.fu[P_FU_CSR];

    // Handshake -----------------------------
    assign stall    = (o_s3_valid && i_s3_busy)                 // Output held
                   || (op.valid && fu_mul && !i_mul_ready);     // Multiply running
    assign op.busy  = stall;
    assign o_accept = op.valid && !stall;

    // Operand select ------------------------
    assign mul_lo = i_mul_product[XLEN-1:0];
    assign mul_hi = i_mul_product[2*XLEN-1:XLEN];
    assign cause  = CAUSE_W'(op.rd); // Zero-extended rd

    assign n_opr_a = ({XLEN{fu_alu}} & alu.result)
                   | ({XLEN{fu_mul}} & ((op.uop.mul == MULHU) ? mul_hi : mul_lo))
                   | ({XLEN{fu_lsu}} & alu.sum)                 // Address
                   | ({XLEN{fu_cfu}} & i_cfu_target)
                   | ({XLEN{fu_csr}} & op.opr_a);

    assign n_opr_b = op.trap ? XLEN'(cause) :
                     ({XLEN{fu_mul}} & mul_hi)
                   | ({XLEN{fu_lsu && op.uop.lsu.store}} & op.opr_c) // Store data
                   | ({XLEN{fu_csr}} & op.opr_c);

    assign n_uop = fu_cfu ? i_cfu_uop : op.uop;

    // Pipeline register ---------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_s3_valid <= 1'b0;
        end else if (i_flush) begin
            o_s3_valid <= 1'b0;
        end else if (o_accept) begin
            o_s3_valid <= 1'b1;
        end else if (!i_s3_busy) begin
            o_s3_valid <= 1'b0; // Taken by stage 3
        end
    end

    always_ff @(posedge g_clk) begin
        if (o_accept) begin
            o_s3_rd    <= op.rd;
            o_s3_uop   <= n_uop;
            o_s3_fu    <= op.fu;
            o_s3_opr_a <= n_opr_a;
            o_s3_opr_b <= n_opr_b;
            o_s3_trap  <= op.trap;
            o_s3_size  <= op.size;
            o_s3_instr <= op.instr;
        end
    end

    // Unit decode relies on exactly one select bit
    a_fu_onehot: assert property (@(posedge g_clk) disable iff (!g_resetn)
        op.valid |-> $onehot(op.fu));

    // Stalled output holds until stage 3 takes it
    a_s3_hold: assert property (@(posedge g_clk) disable iff (!g_resetn || i_flush)
        (o_s3_valid && i_s3_busy) |=> o_s3_valid && $stable({o_s3_rd, o_s3_uop,
        o_s3_fu, o_s3_opr_a, o_s3_opr_b, o_s3_trap, o_s3_size, o_s3_instr}));

endmodule

/* logic/exec_top.sv */
/*
 * Execute stage top level. Plain stage-2 and stage-3 ports, wired to the
 * ALU, branch unit, multiplier and the stage-3 register.
 */
module exec_top import exec_cfg_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic               g_clk,
    input  logic               g_resetn,        // Synchronous, active low

    input  logic               i_s2_valid,
    output logic               o_s2_busy,
    input  logic [FU_W-1:0]    i_s2_fu,
    input  logic [UOP_W-1:0]   i_s2_uop,
    input  logic [RD_W-1:0]    i_s2_rd,
    input  logic [XLEN-1:0]    i_s2_opr_a,
    input  logic [XLEN-1:0]    i_s2_opr_b,
    input  logic [XLEN-1:0]    i_s2_opr_c,
    input  logic               i_s2_trap,
    input  logic [SIZE_W-1:0]  i_s2_size,
    input  logic [INSTR_W-1:0] i_s2_instr,

    input  logic               i_flush,

    output logic               o_s3_valid,
    input  logic               i_s3_busy,
    output logic [RD_W-1:0]    o_s3_rd,
    output logic [UOP_W-1:0]   o_s3_uop,
    output logic [FU_W-1:0]    o_s3_fu,
    output logic [XLEN-1:0]    o_s3_opr_a,
    output logic [XLEN-1:0]    o_s3_opr_b,
    output logic               o_s3_trap,
    output logic [SIZE_W-1:0]  o_s3_size,
    output logic [INSTR_W-1:0] o_s3_instr
);

    exec_op_if  #(.XLEN(XLEN)) s2_if  ();
    exec_alu_if #(.XLEN(XLEN)) alu_if ();

    logic              accept;      // Stage-2 record taken
    logic              mul_ready;
    logic [2*XLEN-1:0] mul_product;
    logic [UOP_W-1:0]  cfu_uop;
    logic [XLEN-1:0]   cfu_target;

    // Stage-2 record in ---------------------
    assign s2_if.valid = i_s2_valid;
    assign s2_if.fu    = i_s2_fu;
    assign s2_if.uop   = i_s2_uop;
    assign s2_if.rd    = i_s2_rd;
    assign s2_if.opr_a = i_s2_opr_a;
    assign s2_if.opr_b = i_s2_opr_b;
    assign s2_if.opr_c = i_s2_opr_c;
    assign s2_if.trap  = i_s2_trap;
    assign s2_if.size  = i_s2_size;
    assign s2_if.instr = i_s2_instr;
    assign o_s2_busy   = s2_if.busy;

    // Units ---------------------------------
    exec_alu #(.XLEN(XLEN)) i_alu (
        .op  (s2_if.unit),
        .res (alu_if.alu)
    );

    exec_branch #(.XLEN(XLEN)) i_branch (
        .op           (s2_if.unit),
        .alu          (alu_if.user),
        .o_cfu_uop    (cfu_uop),
        .o_cfu_target (cfu_target)
    );

    exec_mul #(.XLEN(XLEN)) i_mul (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .i_flush       (i_flush),
        .op            (s2_if.unit),
        .i_accept      (accept),
        .o_mul_ready   (mul_ready),
        .o_mul_product (mul_product)
    );

    exec_s3_register #(.XLEN(XLEN)) i_s3_reg (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .i_flush       (i_flush),
        .op            (s2_if.stage),
        .alu           (alu_if.user),
        .i_cfu_uop     (cfu_uop),
        .i_cfu_target  (cfu_target),
        .i_mul_ready   (mul_ready),
        .i_mul_product (mul_product),
        .o_accept      (accept),
        .i_s3_busy     (i_s3_busy),
        .o_s3_valid    (o_s3_valid),
        .o_s3_rd       (o_s3_rd),
        .o_s3_uop      (o_s3_uop),
        .o_s3_fu       (o_s3_fu),
        .o_s3_opr_a    (o_s3_opr_a),
        .o_s3_opr_b    (o_s3_opr_b),
        .o_s3_trap     (o_s3_trap),
        .o_s3_size     (o_s3_size),
        .o_s3_instr    (o_s3_instr)
    );

endmodule

/* include/exec_tb_cases.svh */
/*
 * Stage-2 records and their expected stage-3 results for the execute-stage
 * testbench. Included inside the testbench module, applied in row order.
 */
`ifndef EXEC_TB_CASES_SVH
`define EXEC_TB_CASES_SVH

// Columns: fu, uop, rd, opr_a, opr_b, opr_c, trap, then expected uop, opr_a, opr_b

localparam logic [FU_W-1:0] F_ALU = FU_W'(1 << P_FU_ALU);
localparam logic [FU_W-1:0] F_MUL = FU_W'(1 << P_FU_MUL);
localparam logic [FU_W-1:0] F_LSU = FU_W'(1 << P_FU_LSU);
localparam logic [FU_W-1:0] F_CFU = FU_W'(1 << P_FU_CFU);
localparam logic [FU_W-1:0] F_CSR = FU_W'(1 << P_FU_CSR);

localparam int NUM_CASES = 26;

typedef struct packed {
    logic [FU_W-1:0] fu;
    exec_uop_u       uop;
    logic [RD_W-1:0] rd;
    logic [XLEN-1:0] opr_a;
    logic [XLEN-1:0] opr_b;
    logic [XLEN-1:0] opr_c;
    logic            trap;
    exec_uop_u       exp_uop;
    logic [XLEN-1:0] exp_a;
    logic [XLEN-1:0] exp_b;
} case_t;

case_t cases [NUM_CASES] = '{
    '{F_MUL, MUL, 5'd1, 'h0001_0003, 'h0002_0005, 'h0, 1'b0, MUL, 'h000b_000f, 'h2},
    '{F_MUL, MULHU, 5'd2, 'hffff_ffff, 'hffff_ffff, 'h0, 1'b0, MULHU, 'hffff_fffe, 'hffff_fffe},
    '{F_MUL, MUL, 5'd3, 'h1234_5678, 'h0000_0010, 'h0, 1'b0, MUL, 'h2345_6780, 'h1},
    '{F_ALU, ADD, 5'd4, 'h0000_1234, 'h0000_0ff0, 'h0, 1'b0, ADD, 'h0000_2224, 'h0},
    '{F_ALU, SUB, 5'd5, 'h0000_0010, 'h0000_0020, 'h0, 1'b0, SUB, 'hffff_fff0, 'h0},
    '{F_ALU, XOR, 5'd6, 'hf0f0_f0f0, 'hff00_ff00, 'h0, 1'b0, XOR, 'h0ff0_0ff0, 'h0},
    '{F_ALU, OR, 5'd7, 'hf0f0_f0f0, 'hff00_ff00, 'h0, 1'b0, OR, 'hfff0_fff0, 'h0},
    '{F_ALU, AND, 5'd8, 'hf0f0_f0f0, 'hff00_ff00, 'h0, 1'b0, AND, 'hf000_f000, 'h0},
    '{F_ALU, SLL, 5'd9, 'h0000_0001, 'h0000_0024, 'h0, 1'b0, SLL, 'h0000_0010, 'h0},
    '{F_ALU, SRL, 5'd10, 'h8000_0000, 'h0000_0004, 'h0, 1'b0, SRL, 'h0800_0000, 'h0},
    '{F_ALU, SRA, 5'd11, 'h8000_0000, 'h0000_0004, 'h0, 1'b0, SRA, 'hf800_0000, 'h0},
    '{F_ALU, SLT, 5'd12, 'hffff_ffff, 'h0000_0001, 'h0, 1'b0, SLT, 'h1, 'h0},
    '{F_ALU, SLTU, 5'd13, 'hffff_ffff, 'h0000_0001, 'h0, 1'b0, SLTU, 'h0, 'h0},
    '{F_CFU, BEQ, 5'd14, 'h5, 'h5, 'h0000_1001, 1'b0, TAKEN, 'h0000_1000, 'h0},
    '{F_CFU, BNE, 5'd15, 'h5, 'h5, 'h0000_2000, 1'b0, NOT_TAKEN, 'h0000_2000, 'h0},
    '{F_CFU, BLT, 5'd16, 'hffff_fffe, 'h1, 'h0000_3000, 1'b0, TAKEN, 'h0000_3000, 'h0},
    '{F_CFU, BGE, 5'd17, 'hffff_fffe, 'h1, 'h0000_3004, 1'b0, NOT_TAKEN, 'h0000_3004, 'h0},
    '{F_CFU, BLTU, 5'd18, 'hffff_fffe, 'h1, 'h0000_4000, 1'b0, NOT_TAKEN, 'h0000_4000, 'h0},
    '{F_CFU, BGEU, 5'd19, 'hffff_fffe, 'h1, 'h0000_4008, 1'b0, TAKEN, 'h0000_4008, 'h0},
    '{F_CFU, JMP, 5'd20, 'h0, 'h0, 'h0000_8003, 1'b0, JMP, 'h0000_8002, 'h0},
    '{F_CFU, JALI, 5'd21, 'h0, 'h0, 'h0000_9000, 1'b0, JALI, 'h0000_9000, 'h0},
    '{F_CFU, JALR, 5'd22, 'h0000_1001, 'h0000_0100, 'hdead_0000, 1'b0, JALR, 'h0000_1100, 'h0},
    '{F_LSU, 5'b010_01, 5'd23, 'h1000_0000, 'h40, 'hcafe_f00d, 1'b0, 5'b010_01, 'h1000_0040, 'h0},
    '{F_LSU, 5'b010_10, 5'd24, 'h1000_0000, 'hffff_fffc, 'h1234_abcd, 1'b0, 5'b010_10,
      'h0fff_fffc, 'h1234_abcd},
    '{F_CSR, 5'd1, 5'd25, 'h0000_0300, 'h0, 'h0000_1888, 1'b0, 5'd1, 'h0000_0300, 'h0000_1888},
    '{F_ALU, ADD, 5'd26, 'h1, 'h2, 'h0, 1'b1, ADD, 'h3, 'h0000_001a}  // Cause is rd
};

`endif

/* tests/exec_tb.sv */
/*
 * Testbench for the execute stage. Flushes a running multiply, then applies
 * the case table under random stage-3 back-pressure and checks every result
 * in order, including that stalled outputs hold.
 */
module exec_tb import exec_cfg_pkg::*, exec_isa_pkg::*; ();

    localparam int XLEN       = XLEN_DEFAULT;
    localparam int CLK_PERIOD = 4;
    localparam int SEED       = 32'h0ed1_0e7b;

    `include "exec_tb_cases.svh"

    localparam int WATCHDOG_TIME = NUM_CASES * (XLEN + 16) * CLK_PERIOD;

    logic               g_clk = 1'b0;
    logic               g_resetn;
    logic               i_s2_valid, i_s2_trap, i_s3_busy, i_flush;
    logic [FU_W-1:0]    i_s2_fu;
    logic [UOP_W-1:0]   i_s2_uop;
    logic [RD_W-1:0]    i_s2_rd;
    logic [XLEN-1:0]    i_s2_opr_a, i_s2_opr_b, i_s2_opr_c;
    logic [SIZE_W-1:0]  i_s2_size;
    logic [INSTR_W-1:0] i_s2_instr;
    logic               o_s2_busy, o_s3_valid, o_s3_trap;
    logic [RD_W-1:0]    o_s3_rd;
    logic [UOP_W-1:0]   o_s3_uop;
    logic [FU_W-1:0]    o_s3_fu;
    logic [XLEN-1:0]    o_s3_opr_a, o_s3_opr_b;
    logic [SIZE_W-1:0]  o_s3_size;
    logic [INSTR_W-1:0] o_s3_instr;

    int                 seed;
    logic               hold_busy;    // Keep stage 3 stalled
    int                 exp_q[$];     // Case indices awaiting a result
    int                 n_seen = 0;   // Results taken by stage 3
    int                 idx;
    logic               held = 1'b0;  // Output was stalled at the last edge
    logic [RD_W-1:0]    held_rd;
    exec_uop_u          held_uop;
    logic [XLEN-1:0]    held_a, held_b;
    logic [FU_W-1:0]    held_fu;
    logic               held_trap;
    logic [SIZE_W-1:0]  held_size;
    logic [INSTR_W-1:0] held_instr;

    exec_top #(.XLEN(XLEN)) i_dut (.*);

    always #(CLK_PERIOD/2) g_clk = ~g_clk;

    // Checks --------------------------------
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got, exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_uop(input string name, input exec_uop_u got, exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_rd(input string name, input logic [RD_W-1:0] got, exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_fu(input string name, input logic [FU_W-1:0] got, exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input logic [SIZE_W-1:0] got, exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_instr(input string name, input logic [INSTR_W-1:0] got, exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Side fields taken from the row, so each record carries its own values
    function automatic logic [SIZE_W-1:0] size_field(input case_t c);
        return c.rd[SIZE_W-1:0];
    endfunction

    function automatic logic [INSTR_W-1:0] instr_word(input case_t c);
        return INSTR_W'(c.opr_a ^ c.opr_c);
    endfunction

    // Driver --------------------------------
    task automatic drive_record(input case_t c);
        i_s2_valid = 1'b1;
        i_s2_fu    = c.fu;
        i_s2_uop   = c.uop;
        i_s2_rd    = c.rd;
        i_s2_opr_a = c.opr_a;
        i_s2_opr_b = c.opr_b;
        i_s2_opr_c = c.opr_c;
        i_s2_trap  = c.trap;
        i_s2_size  = size_field(c);
        i_s2_instr = instr_word(c); // Any word, passed through
    endtask

    // Hold one row until accepted; a multiply must keep busy for XLEN cycles
    task automatic apply_case(input int n);
        int waited;
        bit taken;
        waited = 0;
        taken  = 1'b0;
        @(negedge g_clk);
        drive_record(cases[n]);
        while (!taken) begin
            @(posedge g_clk);
            if (!o_s2_busy) begin
                taken = 1'b1;
                exp_q.push_back(n);
            end else begin
                waited++;
            end
        end
        if (cases[n].fu == F_MUL && waited < XLEN)
            fail_run($sformatf("case %0d: multiply accepted after %0d busy cycles", n, waited));
    endtask

    // Stalled ALU result plus a running multiply, both dropped by one flush
    task automatic flush_during_multiply();
        case_t c;
        @(negedge g_clk);
        c = '{F_ALU, ADD, 5'd30, 'h7, 'h8, 'h0, 1'b0, ADD, 'hf, 'h0};
        drive_record(c);
        @(posedge g_clk);
        if (o_s2_busy) fail_run("flush test: first record was not accepted");
        @(negedge g_clk);
        c = '{F_MUL, MUL, 5'd31, 'h3, 'h5, 'h0, 1'b0, MUL, 'hf, 'h0};
        drive_record(c);
        repeat (XLEN/2) @(posedge g_clk);                   // Multiply half done
        @(negedge g_clk);
        if (!o_s3_valid || !o_s2_busy) fail_run("flush test: pipeline not stalled before flush");
        i_flush    = 1'b1;
        i_s2_valid = 1'b0;                                  // Upstream drops its record too
        @(negedge g_clk);
        i_flush = 1'b0;
        if (o_s3_valid) fail_run("flush test: o_s3_valid still high after flush");
        if (o_s2_busy) fail_run("flush test: o_s2_busy still high after flush");
        @(posedge g_clk);
        hold_busy = 1'b0;                                   // Random back-pressure from here
    endtask

    // Random stage-3 back-pressure
    always @(negedge g_clk) begin
        i_s3_busy = hold_busy ? 1'b1 : (($random(seed) & 1) != 0);
    end

    // Monitor -------------------------------
    always @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            held = 1'b0;
        end else begin
            if (held) begin                                 // Stalled output must not move
                if (!o_s3_valid) fail_run("o_s3_valid dropped while stage 3 was busy");
                check_rd("o_s3_rd (held)", o_s3_rd, held_rd);
                check_uop("o_s3_uop (held)", o_s3_uop, held_uop);
                check_word("o_s3_opr_a (held)", o_s3_opr_a, held_a);
                check_word("o_s3_opr_b (held)", o_s3_opr_b, held_b);
                check_fu("o_s3_fu (held)", o_s3_fu, held_fu);
                check_flag("o_s3_trap (held)", o_s3_trap, held_trap);
                check_size("o_s3_size (held)", o_s3_size, held_size);
                check_instr("o_s3_instr (held)", o_s3_instr, held_instr);
            end
            if (o_s3_valid && !i_s3_busy) begin
                if (exp_q.size() == 0) fail_run("stage 3 took a result that was never sent");
                idx = exp_q.pop_front();
                check_rd($sformatf("o_s3_rd case %0d", idx), o_s3_rd, cases[idx].rd);
                check_uop($sformatf("o_s3_uop case %0d", idx), o_s3_uop, cases[idx].exp_uop);
                check_word($sformatf("o_s3_opr_a case %0d", idx), o_s3_opr_a, cases[idx].exp_a);
                check_word($sformatf("o_s3_opr_b case %0d", idx), o_s3_opr_b, cases[idx].exp_b);
                check_fu($sformatf("o_s3_fu case %0d", idx), o_s3_fu, cases[idx].fu);
                check_flag($sformatf("o_s3_trap case %0d", idx), o_s3_trap, cases[idx].trap);
                check_size($sformatf("o_s3_size case %0d", idx), o_s3_size,
                           size_field(cases[idx]));
                check_instr($sformatf("o_s3_instr case %0d", idx), o_s3_instr,
                            instr_word(cases[idx]));
                n_seen++;
            end
            held       = o_s3_valid && i_s3_busy;
            held_rd    = o_s3_rd;
            held_uop   = o_s3_uop;
            held_a     = o_s3_opr_a;
            held_b     = o_s3_opr_b;
            held_fu    = o_s3_fu;
            held_trap  = o_s3_trap;
            held_size  = o_s3_size;
            held_instr = o_s3_instr;
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        fail_run($sformatf("run timed out after %0d time units", WATCHDOG_TIME));
    end

    // Main sequence -------------------------
    initial begin
        seed       = SEED;
        hold_busy  = 1'b1;
        g_resetn   = 1'b0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b1;
        i_s2_valid = 1'b0;
        i_s2_fu    = '0;
        i_s2_uop   = '0;
        i_s2_rd    = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_s2_trap  = 1'b0;
        i_s2_size  = '0;
        i_s2_instr = '0;
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        if (o_s3_valid || o_s2_busy) fail_run("o_s3_valid or o_s2_busy high after reset");

        flush_during_multiply();
        for (int n = 0; n < NUM_CASES; n++) begin
            apply_case(n);
        end
        @(negedge g_clk);
        i_s2_valid = 1'b0;

        while (exp_q.size() != 0) @(negedge g_clk);
        repeat (4) @(negedge g_clk);                        // Catch any extra result

        if (n_seen == NUM_CASES) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d results seen, %0d expected", n_seen, NUM_CASES));
        end
    end

endmodule

/* all.f */
+incdir+include
logic/exec_cfg_pkg.sv
logic/exec_isa_pkg.sv
logic/exec_op_if.sv
logic/exec_alu_if.sv
logic/exec_alu.sv
logic/exec_branch.sv
logic/exec_mul.sv
logic/exec_s3_register.sv
logic/exec_top.sv
tests/exec_tb.sv
